// ==== core_pkg.sv ====
package core_pkg;

  //////////////////////////////
  // widths and sizes
  //////////////////////////////

  localparam int XLEN        = 32;
  localparam int NUM_REGS    = 32;
  localparam int QUEUE_DEPTH = 4;
  localparam int MUL_STEPS   = 32;

  typedef logic [XLEN-1:0]             word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
  typedef logic [3:0]                  alu_op_t;

  // alu operation codes
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;
  localparam alu_op_t ALU_PASS = 4'd10;

  //////////////////////////////
  // instruction encodings
  //////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_SLL  = 3'b001;
  localparam logic [2:0] FUNCT3_SLT  = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU = 3'b011;
  localparam logic [2:0] FUNCT3_XOR  = 3'b100;
  localparam logic [2:0] FUNCT3_SR   = 3'b101;
  localparam logic [2:0] FUNCT3_OR   = 3'b110;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;

  localparam logic [2:0] FUNCT3_MUL   = 3'b000;
  localparam logic [2:0] FUNCT3_MULHU = 3'b011;

  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_RUN,
    MUL_DONE
  } mul_state_t;

endpackage

// ==== issue_if.sv ====
`timescale 1ns/1ps

interface issue_if;

  logic               valid;
  logic               ready;
  core_pkg::alu_op_t  alu_op;
  core_pkg::reg_addr_t rs1;
  core_pkg::reg_addr_t rs2;
  core_pkg::reg_addr_t rd;
  core_pkg::word_t    imm;
  logic               use_imm;
  logic               is_mul;
  logic               mul_high;
  logic               writes_rd;

  modport decoder (
    output valid, alu_op, rs1, rs2, rd, imm, use_imm, is_mul, mul_high, writes_rd,
    input  ready
  );

  modport exec (
    input  valid, alu_op, rs1, rs2, rd, imm, use_imm, is_mul, mul_high, writes_rd,
    output ready
  );

endinterface

// ==== instr_queue.sv ====
`timescale 1ns/1ps

module instr_queue (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            push_i,
  input  core_pkg::word_t push_instr_i,
  output logic            head_valid_o,
  output core_pkg::word_t head_instr_o,
  input  logic            pop_i,
  output logic            credit_o
);

  core_pkg::word_t entries_q [core_pkg::QUEUE_DEPTH];

  logic [$clog2(core_pkg::QUEUE_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(core_pkg::QUEUE_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(core_pkg::QUEUE_DEPTH+1)-1:0] count_q;
  logic                                       credit_q;

  assign head_valid_o = (count_q != '0);
  assign head_instr_o = entries_q[rd_ptr_q];
  assign credit_o     = credit_q;

  // storage, written only under a held credit
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      entries_q[wr_ptr_q] <= push_instr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == core_pkg::QUEUE_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == core_pkg::QUEUE_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // one credit back per released entry
      credit_q <= pop_i;
    end
  end

endmodule

// ==== decoder.sv ====
`timescale 1ns/1ps

module decoder (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            head_valid_i,
  input  core_pkg::word_t head_instr_i,
  output logic            pop_o,
  issue_if.decoder        issue
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  core_pkg::alu_op_t dec_op;
  core_pkg::word_t   dec_imm;
  logic              dec_use_imm;
  logic              dec_is_mul;
  logic              dec_high;
  logic              dec_ok;

  function automatic core_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      core_pkg::FUNCT3_ADD:  alu_sel = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      core_pkg::FUNCT3_SLL:  alu_sel = core_pkg::ALU_SLL;
      core_pkg::FUNCT3_SLT:  alu_sel = core_pkg::ALU_SLT;
      core_pkg::FUNCT3_SLTU: alu_sel = core_pkg::ALU_SLTU;
      core_pkg::FUNCT3_XOR:  alu_sel = core_pkg::ALU_XOR;
      core_pkg::FUNCT3_SR:   alu_sel = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      core_pkg::FUNCT3_OR:   alu_sel = core_pkg::ALU_OR;
      default:               alu_sel = core_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode = head_instr_i[6:0];
  assign funct3 = head_instr_i[14:12];
  assign funct7 = head_instr_i[31:25];

  always_comb begin
    dec_op      = core_pkg::ALU_ADD;
    dec_imm     = {{20{head_instr_i[31]}}, head_instr_i[31:20]};
    dec_use_imm = 1'b0;
    dec_is_mul  = 1'b0;
    dec_high    = 1'b0;
    dec_ok      = 1'b0;
    case (opcode)
      core_pkg::OPC_OP: begin
        if (funct7 == core_pkg::FUNCT7_MULDIV) begin
          // only MUL and MULHU kept from the M extension
          dec_is_mul = (funct3 == core_pkg::FUNCT3_MUL) || (funct3 == core_pkg::FUNCT3_MULHU);
          dec_high   = (funct3 == core_pkg::FUNCT3_MULHU);
          dec_ok     = dec_is_mul;
        end else begin
          dec_op = alu_sel(funct3, funct7[5]);
          dec_ok = (funct7 == core_pkg::FUNCT7_BASE) ||
                   ((funct7 == core_pkg::FUNCT7_ALT) &&
                    ((funct3 == core_pkg::FUNCT3_ADD) || (funct3 == core_pkg::FUNCT3_SR)));
        end
      end
      core_pkg::OPC_OP_IMM: begin
        dec_use_imm = 1'b1;
        // ADDI never becomes SUB, imm bit 10 is data there
        dec_op = alu_sel(funct3, (funct3 == core_pkg::FUNCT3_SR) && funct7[5]);
        dec_ok = ((funct3 != core_pkg::FUNCT3_SLL) && (funct3 != core_pkg::FUNCT3_SR)) ||
                 (funct7 == core_pkg::FUNCT7_BASE) ||
                 ((funct3 == core_pkg::FUNCT3_SR) && (funct7 == core_pkg::FUNCT7_ALT));
      end
      core_pkg::OPC_LUI: begin
        dec_op      = core_pkg::ALU_PASS;
        dec_imm     = {head_instr_i[31:12], 12'b0};
        dec_use_imm = 1'b1;
        dec_ok      = 1'b1;
      end
      default: begin
        dec_ok = 1'b0;
      end
    endcase
  end

  // take a new word when the stage is empty or draining
  assign pop_o = head_valid_i && (!issue.valid || issue.ready);

  //////////////////////////////
  // stage register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      issue.valid <= 1'b0;
    end else if (pop_o) begin
      issue.valid <= 1'b1;
    end else if (issue.ready) begin
      issue.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      issue.alu_op    <= dec_op;
      issue.rs1       <= head_instr_i[19:15];
      issue.rs2       <= head_instr_i[24:20];
      issue.rd        <= head_instr_i[11:7];
      issue.imm       <= dec_imm;
      issue.use_imm   <= dec_use_imm;
      issue.is_mul    <= dec_is_mul;
      issue.mul_high  <= dec_high;
      issue.writes_rd <= dec_ok && (head_instr_i[11:7] != '0);
    end
  end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                clk_i,
  input  core_pkg::reg_addr_t rs1_addr_i,
  input  core_pkg::reg_addr_t rs2_addr_i,
  output core_pkg::word_t     rs1_data_o,
  output core_pkg::word_t     rs2_data_o,
  input  logic                we_i,
  input  core_pkg::reg_addr_t rd_addr_i,
  input  core_pkg::word_t     rd_data_i
);

  core_pkg::word_t regs_q [core_pkg::NUM_REGS];

  // x0 always reads zero
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

  always_ff @(posedge clk_i) begin
    if (we_i && (rd_addr_i != '0)) begin
      regs_q[rd_addr_i] <= rd_data_i;
    end
  end

endmodule

// ==== mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            start_i,
  input  core_pkg::word_t a_i,
  input  core_pkg::word_t b_i,
  input  logic            high_i,
  output core_pkg::word_t result_o,
  output logic            done_o
);

  core_pkg::mul_state_t                    state_q;
  logic [$clog2(core_pkg::MUL_STEPS)-1:0]  step_q;
  logic [2*core_pkg::XLEN-1:0]             prod_q;
  core_pkg::word_t                         mcand_q;
  logic                                    high_q;
  core_pkg::word_t                         addend;
  logic [core_pkg::XLEN:0]                 sum;

  // upper half accumulates, lower half shifts the multiplier out
  assign addend = prod_q[0] ? mcand_q : '0;
  assign sum    = {1'b0, prod_q[2*core_pkg::XLEN-1:core_pkg::XLEN]} + {1'b0, addend};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= core_pkg::MUL_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        core_pkg::MUL_IDLE: begin
          if (start_i) begin
            state_q <= core_pkg::MUL_RUN;
            step_q  <= '0;
          end
        end
        core_pkg::MUL_RUN: begin
          step_q <= step_q + 1'b1;
          if (step_q == core_pkg::MUL_STEPS - 1) begin
            state_q <= core_pkg::MUL_DONE;
          end
        end
        default: begin
          state_q <= core_pkg::MUL_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && (state_q == core_pkg::MUL_IDLE)) begin
      prod_q  <= {{core_pkg::XLEN{1'b0}}, b_i};
      mcand_q <= a_i;
      high_q  <= high_i;
    end else if (state_q == core_pkg::MUL_RUN) begin
      prod_q <= {sum, prod_q[core_pkg::XLEN-1:1]};
    end
  end

  assign done_o   = (state_q == core_pkg::MUL_DONE);
  assign result_o = high_q ? prod_q[2*core_pkg::XLEN-1:core_pkg::XLEN]
                           : prod_q[core_pkg::XLEN-1:0];

endmodule

// ==== exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage (
  input  logic                clk_i,
  input  logic                reset_i,
  issue_if.exec               issue,
  output core_pkg::reg_addr_t rs1_addr_o,
  output core_pkg::reg_addr_t rs2_addr_o,
  input  core_pkg::word_t     rs1_data_i,
  input  core_pkg::word_t     rs2_data_i,
  output logic                wb_valid_o,
  output core_pkg::reg_addr_t wb_rd_o,
  output core_pkg::word_t     wb_data_o
);

  logic                accept;
  logic                mul_start;
  logic                mul_done;
  logic                mul_busy_q;
  core_pkg::reg_addr_t mul_rd_q;
  logic                mul_wr_q;
  core_pkg::word_t     mul_result;
  core_pkg::word_t     op_a;
  core_pkg::word_t     op_b_reg;
  core_pkg::word_t     op_b;
  core_pkg::word_t     alu_result;
  logic [4:0]          shamt;
  logic                wb_valid_q;
  core_pkg::reg_addr_t wb_rd_q;
  core_pkg::word_t     wb_data_q;

  assign rs1_addr_o = issue.rs1;
  assign rs2_addr_o = issue.rs2;

  // stall from mul acceptance through its done cycle
  assign issue.ready = !mul_busy_q;
  assign accept      = issue.valid && issue.ready;
  assign mul_start   = accept && issue.is_mul;

  //////////////////////////////
  // operands
  //////////////////////////////

  assign op_a     = (wb_valid_q && (wb_rd_q == issue.rs1)) ? wb_data_q : rs1_data_i;
  assign op_b_reg = (wb_valid_q && (wb_rd_q == issue.rs2)) ? wb_data_q : rs2_data_i;
  assign op_b     = issue.use_imm ? issue.imm : op_b_reg;
  assign shamt    = op_b[4:0];

  always_comb begin
    case (issue.alu_op)
      core_pkg::ALU_ADD:  alu_result = op_a + op_b;
      core_pkg::ALU_SUB:  alu_result = op_a - op_b;
      core_pkg::ALU_SLL:  alu_result = op_a << shamt;
      core_pkg::ALU_SLT:  alu_result = core_pkg::word_t'($signed(op_a) < $signed(op_b));
      core_pkg::ALU_SLTU: alu_result = core_pkg::word_t'(op_a < op_b);
      core_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
      core_pkg::ALU_SRL:  alu_result = op_a >> shamt;
      core_pkg::ALU_SRA:  alu_result = core_pkg::word_t'($signed(op_a) >>> shamt);
      core_pkg::ALU_OR:   alu_result = op_a | op_b;
      core_pkg::ALU_AND:  alu_result = op_a & op_b;
      core_pkg::ALU_PASS: alu_result = op_b;
      default:            alu_result = '0;
    endcase
  end

  mul_unit u_mul (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .start_i  (mul_start),
    .a_i      (op_a),
    .b_i      (op_b),
    .high_i   (issue.mul_high),
    .result_o (mul_result),
    .done_o   (mul_done)
  );

  //////////////////////////////
  // writeback register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mul_busy_q <= 1'b0;
      wb_valid_q <= 1'b0;
    end else begin
      if (mul_start) begin
        mul_busy_q <= 1'b1;
      end else if (mul_done) begin
        mul_busy_q <= 1'b0;
      end
      wb_valid_q <= (accept && !issue.is_mul && issue.writes_rd) || (mul_done && mul_wr_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (mul_start) begin
      mul_rd_q <= issue.rd;
      mul_wr_q <= issue.writes_rd;
    end
    // done and accept never share a cycle
    if (mul_done) begin
      wb_rd_q   <= mul_rd_q;
      wb_data_q <= mul_result;
    end else if (accept && !issue.is_mul) begin
      wb_rd_q   <= issue.rd;
      wb_data_q <= alu_result;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_rd_o    = wb_rd_q;
  assign wb_data_o  = wb_data_q;

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                instr_valid_i,
  input  core_pkg::word_t     instr_i,
  output logic                credit_o,
  output logic                wb_valid_o,
  output core_pkg::reg_addr_t wb_rd_o,
  output core_pkg::word_t     wb_data_o
);

  logic                head_valid;
  core_pkg::word_t     head_instr;
  logic                pop;
  core_pkg::reg_addr_t rs1_addr;
  core_pkg::reg_addr_t rs2_addr;
  core_pkg::word_t     rs1_data;
  core_pkg::word_t     rs2_data;

  issue_if issue_bus ();

  instr_queue u_queue (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_i       (instr_valid_i),
    .push_instr_i (instr_i),
    .head_valid_o (head_valid),
    .head_instr_o (head_instr),
    .pop_i        (pop),
    .credit_o     (credit_o)
  );

  decoder u_decoder (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .head_valid_i (head_valid),
    .head_instr_i (head_instr),
    .pop_o        (pop),
    .issue        (issue_bus)
  );

  // write port fed straight from the writeback register
  reg_file u_regs (
    .clk_i      (clk_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (wb_valid_o),
    .rd_addr_i  (wb_rd_o),
    .rd_data_i  (wb_data_o)
  );

  exec_stage u_exec (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .issue      (issue_bus),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o)
  );

endmodule

// ==== rv_core_props.sv ====
`timescale 1ns/1ps

module rv_core_props (
  input logic                clk_i,
  input logic                reset_i,
  input logic                wb_valid_i,
  input core_pkg::reg_addr_t wb_rd_i,
  input logic                issue_valid_i,
  input logic                issue_ready_i,
  input logic [54:0]         issue_fields_i,
  input logic                mul_done_i
);

  // x0 is never an architectural target
  wb_rd_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_valid_i |-> (wb_rd_i != '0))
    else $error("writeback valid with rd x0");

  // stalled issue keeps valid and every field
  issue_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (issue_valid_i && !issue_ready_i) |=> (issue_valid_i && $stable(issue_fields_i)))
    else $error("issue dropped or changed while stalled");

  mul_done_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    mul_done_i |=> !mul_done_i)
    else $error("multiplier done held longer than one cycle");

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

  localparam int          SEED        = 12662;
  localparam int          TABLE_LEN   = 64;
  localparam int          CYCLE_LIMIT = TABLE_LEN * (core_pkg::MUL_STEPS + 6) + 50;
  localparam logic [6:0]  OP_R        = 7'b0110011;
  localparam logic [6:0]  OP_I        = 7'b0010011;
  localparam logic [6:0]  OP_LUI      = 7'b0110111;
  localparam logic [6:0]  OP_LOAD     = 7'b0000011;

  logic                clk_i = 1'b0;
  logic                reset_i;
  logic                instr_valid_i;
  core_pkg::word_t     instr_i;
  logic                credit_o;
  logic                wb_valid_o;
  core_pkg::reg_addr_t wb_rd_o;
  core_pkg::word_t     wb_data_o;

  // stimulus table and expected writes
  core_pkg::word_t     instr_tbl [TABLE_LEN];
  core_pkg::reg_addr_t exp_rd    [TABLE_LEN];
  core_pkg::word_t     exp_val   [TABLE_LEN];
  core_pkg::word_t     ref_regs  [32];
  int                  n_instr     = 0;
  int                  n_exp       = 0;
  int                  next_idx    = 0;
  int                  wb_idx      = 0;
  int                  credits     = core_pkg::QUEUE_DEPTH;
  int                  avail;
  int                  cycle_count = 0;
  logic [31:0]         rng         = SEED;

  rv_core uut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .credit_o      (credit_o),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  bind rv_core rv_core_props props (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .wb_valid_i     (wb_valid_o),
    .wb_rd_i        (wb_rd_o),
    .issue_valid_i  (issue_bus.valid),
    .issue_ready_i  (issue_bus.ready),
    .issue_fields_i ({issue_bus.alu_op, issue_bus.rs1, issue_bus.rs2, issue_bus.rd,
                      issue_bus.imm, issue_bus.use_imm, issue_bus.is_mul,
                      issue_bus.mul_high, issue_bus.writes_rd}),
    .mul_done_i     (u_exec.mul_done)
  );

  always #50 clk_i = ~clk_i;

  //////////////////////////////
  // encoders and reference model
  //////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic core_pkg::word_t rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_R};
  endfunction

  function automatic core_pkg::word_t itype(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OP_I};
  endfunction

  function automatic core_pkg::word_t utype(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OP_LUI};
  endfunction

  // RV32I integer op where alt selects SUB or SRA
  function automatic core_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                              input core_pkg::word_t a,
                                              input core_pkg::word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic append_instr(input core_pkg::word_t w);
    logic [4:0]      rd;
    logic [2:0]      f3;
    logic [6:0]      f7;
    core_pkg::word_t a;
    core_pkg::word_t b;
    core_pkg::word_t imm;
    logic [63:0]     prod;
    logic            wr;
    core_pkg::word_t val;
    rd   = w[11:7];
    f3   = w[14:12];
    f7   = w[31:25];
    a    = ref_regs[w[19:15]];
    b    = ref_regs[w[24:20]];
    imm  = {{20{w[31]}}, w[31:20]};
    prod = {32'b0, a} * {32'b0, b};
    wr   = 1'b0;
    val  = '0;
    case (w[6:0])
      OP_R: begin
        if (f7 == 7'h01) begin
          // MUL and MULHU only
          wr  = (f3 == 3'd0) || (f3 == 3'd3);
          val = (f3 == 3'd3) ? prod[63:32] : prod[31:0];
        end else if ((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)))) begin
          wr  = 1'b1;
          val = alu_ref(f3, f7[5], a, b);
        end
      end
      OP_I: begin
        wr  = (f3 == 3'd1) ? (f7 == 7'h00) :
              (f3 == 3'd5) ? ((f7 == 7'h00) || (f7 == 7'h20)) : 1'b1;
        val = alu_ref(f3, (f3 == 3'd5) && f7[5], a, imm);
      end
      OP_LUI: begin
        wr  = 1'b1;
        val = {w[31:12], 12'b0};
      end
      default: begin
        wr = 1'b0;
      end
    endcase
    instr_tbl[n_instr] = w;
    n_instr = n_instr + 1;
    if (wr && (rd != 5'd0)) begin
      ref_regs[rd]   = val;
      exp_rd[n_exp]  = rd;
      exp_val[n_exp] = val;
      n_exp = n_exp + 1;
    end
  endtask

  task automatic build_program();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    ref_regs[0] = '0;
    // random values into x1..x8
    for (int i = 1; i <= 8; i++) begin
      rng = lcg_next(rng);
      append_instr(utype(rng[31:12], 5'(i)));
      rng = lcg_next(rng);
      append_instr(itype(rng[31:20], 5'(i), 3'd0, 5'(i)));
    end
    // dependent register chain
    append_instr(rtype(7'h00, 5'd2, 5'd1, 3'd0, 5'd9));
    append_instr(rtype(7'h20, 5'd3, 5'd9, 3'd0, 5'd10));
    append_instr(rtype(7'h00, 5'd4, 5'd10, 3'd1, 5'd11));
    append_instr(rtype(7'h00, 5'd5, 5'd11, 3'd2, 5'd12));
    append_instr(rtype(7'h00, 5'd12, 5'd6, 3'd3, 5'd13));
    append_instr(rtype(7'h00, 5'd7, 5'd13, 3'd4, 5'd14));
    append_instr(rtype(7'h00, 5'd8, 5'd14, 3'd5, 5'd15));
    append_instr(rtype(7'h20, 5'd3, 5'd1, 3'd5, 5'd16));
    append_instr(rtype(7'h00, 5'd4, 5'd16, 3'd6, 5'd17));
    append_instr(rtype(7'h00, 5'd5, 5'd17, 3'd7, 5'd18));
    // immediate chain
    append_instr(itype(12'hffb, 5'd18, 3'd0, 5'd19));
    append_instr(itype(12'h123, 5'd19, 3'd2, 5'd20));
    append_instr(itype(12'h800, 5'd20, 3'd3, 5'd21));
    append_instr(itype(12'hfff, 5'd19, 3'd4, 5'd22));
    append_instr(itype(12'h0f0, 5'd22, 3'd6, 5'd23));
    append_instr(itype(12'h7c3, 5'd23, 3'd7, 5'd24));
    append_instr(itype(12'h007, 5'd24, 3'd1, 5'd25));
    append_instr(itype(12'h00b, 5'd25, 3'd5, 5'd26));
    append_instr(itype({7'h20, 5'd13}, 5'd1, 3'd5, 5'd27));
    append_instr(utype(20'h8badc, 5'd28));
    // multiplies with dependents behind them
    append_instr(rtype(7'h01, 5'd2, 5'd1, 3'd0, 5'd29));
    append_instr(rtype(7'h01, 5'd3, 5'd29, 3'd3, 5'd30));
    append_instr(rtype(7'h00, 5'd29, 5'd30, 3'd0, 5'd31));
    append_instr(rtype(7'h01, 5'd4, 5'd4, 3'd3, 5'd9));
    append_instr(rtype(7'h01, 5'd6, 5'd5, 3'd0, 5'd0));
    // rd zero and unsupported words
    append_instr(rtype(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
    append_instr({12'h004, 5'd1, 3'b010, 5'd10, OP_LOAD});
    append_instr(rtype(7'h01, 5'd2, 5'd1, 3'd1, 5'd11));
    append_instr(rtype(7'h20, 5'd2, 5'd1, 3'd4, 5'd12));
    append_instr(itype({7'h20, 5'd3}, 5'd1, 3'd1, 5'd13));
    append_instr(rtype(7'h00, 5'd11, 5'd10, 3'd0, 5'd14));
    append_instr(rtype(7'h00, 5'd13, 5'd12, 3'd6, 5'd15));
    // random mix over x0..x7 fills the rest
    while (n_instr < TABLE_LEN) begin
      rng = lcg_next(rng);
      rd  = {2'b00, rng[18:16]};
      rs1 = {2'b00, rng[21:19]};
      rs2 = {2'b00, rng[24:22]};
      f3  = rng[27:25];
      case (rng[31:29])
        3'd0, 3'd1: append_instr(rtype(7'h00, rs2, rs1, f3, rd));
        3'd2: append_instr(rtype(((f3 == 3'd0) || (f3 == 3'd5)) ? 7'h20 : 7'h00,
                                 rs2, rs1, f3, rd));
        3'd3: append_instr(rtype(7'h01, rs2, rs1, rng[28] ? 3'd3 : 3'd0, rd));
        default: begin
          rng = lcg_next(rng);
          imm = rng[31:20];
          if (f3 == 3'd1) begin
            imm[11:5] = 7'h00;
          end
          if (f3 == 3'd5) begin
            imm[11:5] = imm[11] ? 7'h20 : 7'h00;
          end
          append_instr(itype(imm, rs1, f3, rd));
        end
      endcase
    end
  endtask

  task automatic report_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  //////////////////////////////
  // driver, checker, watchdog
  //////////////////////////////

  // random idle gaps between words sent under a held credit
  always @(posedge clk_i) begin
    if (reset_i) begin
      instr_valid_i <= 1'b0;
      credits = core_pkg::QUEUE_DEPTH;
    end else begin
      avail = credits + (credit_o ? 1 : 0);
      assert (avail <= core_pkg::QUEUE_DEPTH) else begin
        $display("credit returned while all %0d credits were already held",
                 core_pkg::QUEUE_DEPTH);
        report_failure();
      end
      rng = lcg_next(rng);
      if ((next_idx < TABLE_LEN) && (avail > 0) && (rng[31:30] != 2'b00)) begin
        instr_valid_i <= 1'b1;
        instr_i       <= instr_tbl[next_idx];
        next_idx = next_idx + 1;
        avail = avail - 1;
      end else begin
        instr_valid_i <= 1'b0;
      end
      credits = avail;
    end
  end

  always @(negedge clk_i) begin
    if (!reset_i && wb_valid_o) begin
      assert (wb_idx < n_exp) else begin
        $display("writeback to x%0d after all expected results had retired", wb_rd_o);
        report_failure();
      end
      assert (wb_rd_o == exp_rd[wb_idx]) else begin
        $display("[ERROR] %0t wb_rd_o got %0d expected %0d", $time, wb_rd_o, exp_rd[wb_idx]);
        report_failure();
      end
      assert (wb_data_o == exp_val[wb_idx]) else begin
        $display("[ERROR] %0t wb_data_o got 0x%08h expected 0x%08h",
                 $time, wb_data_o, exp_val[wb_idx]);
        report_failure();
      end
      wb_idx = wb_idx + 1;
    end
  end

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with %0d of %0d results retired",
               cycle_count, wb_idx, n_exp);
      report_failure();
    end
  end

  initial begin
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    build_program();
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    assert (credit_o == 1'b0) else begin
      $display("[ERROR] %0t credit_o got %b expected 0", $time, credit_o);
      report_failure();
    end
    assert (wb_valid_o == 1'b0) else begin
      $display("[ERROR] %0t wb_valid_o got %b expected 0", $time, wb_valid_o);
      report_failure();
    end
    while (!((next_idx == TABLE_LEN) && (wb_idx == n_exp) &&
             (credits == core_pkg::QUEUE_DEPTH))) begin
      @(negedge clk_i);
    end
    // a stray writeback or credit would trip a check in this window
    repeat (core_pkg::MUL_STEPS + 4) @(negedge clk_i);
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== flist.f ====
core_pkg.sv
issue_if.sv
instr_queue.sv
decoder.sv
reg_file.sv
mul_unit.sv
exec_stage.sv
rv_core.sv
rv_core_props.sv
tb_rv_core.sv

// ==== Makefile ====
TOP = tb_rv_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir
